// File: cache_2way.sv
`timescale 1ns/1ps

module cache_2way
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
(
	input	logic						clock_i,
	input	logic						reset_i,
	input	logic [31:0]				comm_i,			// counter select and clear
	output	logic [31:0]				comm_o,

	// core
	input	logic						core_req_i,
	input	logic						core_rw_i,		// 1: write
	input	logic [BW_WORD_ADDR-1:0]	core_add_i,
	input	logic [31:0]				core_data_i,
	output	logic						core_done_o,
	output	logic [31:0]				core_data_o,

	// buffer side
	input	logic						ready_req_i,	// command accepted
	input	logic						ready_write_i,	// buffer takes a word
	input	logic						ready_read_i,	// buffer offers a word
	input	logic [31:0]				data_i,
	output	logic						hit_o,
	output	logic						req_o,
	output	logic						rw_o,
	output	logic						write_o,
	output	logic						read_o,
	output	logic [BW_WORD_ADDR-1:0]	add_o,			// block base address
	output	logic [31:0]				data_o
);

	cache_addr_u						core_addr;
	mem_cmd_t							mem_cmd;
	perf_flags_t						flags;
	logic								tag_lookup, tag_upd, tag_upd_way, tag_upd_valid;
	logic								tag_upd_dirty, tag_touch, tag_touch_way;
	logic								tag_hit, tag_hit_way, victim_way, victim_dirty;
	logic [BW_TAG-1:0]					victim_tag;
	logic [BW_CACHE_ADDR_FULL-1:0]		ram_addr;
	logic								ram_wren;
	logic [31:0]						ram_wdata;

	assign core_addr = core_add_i;					// flat word into tag|group|word
	assign req_o = mem_cmd.req;
	assign rw_o = mem_cmd.rw;
	assign add_o = mem_cmd.add;

	// stages
	// ----------------------------------------
	cache_tag_memory tag_mem_inst (
		.clock_i(clock_i), .reset_i(reset_i), .lookup_i(tag_lookup), .addr_i(core_addr),
		.upd_i(tag_upd), .upd_way_i(tag_upd_way), .upd_valid_i(tag_upd_valid),
		.upd_dirty_i(tag_upd_dirty), .touch_i(tag_touch), .touch_way_i(tag_touch_way),
		.hit_o(tag_hit), .hit_way_o(tag_hit_way), .victim_way_o(victim_way),
		.victim_tag_o(victim_tag), .victim_dirty_o(victim_dirty)
	);

	cache_controller cache_contr_inst (
		.clock_i(clock_i), .reset_i(reset_i),
		.core_req_i(core_req_i), .core_rw_i(core_rw_i), .core_addr_i(core_addr),
		.core_data_i(core_data_i), .core_done_o(core_done_o), .core_hit_o(hit_o),
		.tag_lookup_o(tag_lookup), .tag_upd_o(tag_upd), .tag_upd_way_o(tag_upd_way),
		.tag_upd_valid_o(tag_upd_valid), .tag_upd_dirty_o(tag_upd_dirty),
		.tag_touch_o(tag_touch), .tag_touch_way_o(tag_touch_way),
		.tag_hit_i(tag_hit), .tag_hit_way_i(tag_hit_way), .tag_victim_way_i(victim_way),
		.tag_victim_tag_i(victim_tag), .tag_victim_dirty_i(victim_dirty),
		.mem_addr_o(ram_addr), .mem_wren_o(ram_wren), .mem_wdata_o(ram_wdata),
		.mem_rdata_i(core_data_o),
		.ready_req_i(ready_req_i), .mem_cmd_o(mem_cmd), .ready_write_i(ready_write_i),
		.write_o(write_o), .data_o(data_o), .ready_read_i(ready_read_i), .read_o(read_o),
		.data_i(data_i), .flags_o(flags)
	);

	cache_data_memory cache_mem_inst (
		.clock_i(clock_i), .addr_i(ram_addr), .wren_i(ram_wren),
		.data_i(ram_wdata), .data_o(core_data_o)
	);

	cache_perf_counters perf_cont_inst (
		.clock_i(clock_i), .reset_i(reset_i), .flags_i(flags),
		.comm_i(comm_i), .comm_o(comm_o)
	);

endmodule

// File: cache_bus_pkg.sv
package cache_bus_pkg;

	import cache_cfg_pkg::*;

	// memory side command
	// ----------------------------------------
	typedef struct packed {
		logic						req;			// held until ready_req_i
		logic						rw;				// 1: write, 0: read
		logic [BW_WORD_ADDR-1:0]	add;			// block base, word bits zero
	} mem_cmd_t;

	// controller to counters, one-cycle pulses
	typedef struct packed {
		logic	hit;								// first-try hit
		logic	miss;								// once per missing request
		logic	writeback;							// once per dirty eviction
	} perf_flags_t;

	// comm port encoding
	// ----------------------------------------
	localparam logic [1:0] COMM_SEL_HIT = 2'd0;
	localparam logic [1:0] COMM_SEL_MISS = 2'd1;
	localparam logic [1:0] COMM_SEL_WB = 2'd2;
	localparam int COMM_CLEAR_BIT = 31;				// clears all counters

endpackage

// File: cache_cfg_pkg.sv
package cache_cfg_pkg;

	// geometry
	// ----------------------------------------
	localparam int BW_WORD_ADDR = 16;					// core word address
	localparam int BW_BLOCK = 2;						// 4 words per block
	localparam int BW_GRP = 5;							// 32 groups
	localparam int BW_TAG = BW_WORD_ADDR - BW_GRP - BW_BLOCK;	// 9 tag bits
	localparam int N_WAYS = 2;							// set size

	// data ram address is [way|group|word]
	localparam int BW_CACHE_ADDR_FULL = $clog2(N_WAYS) + BW_GRP + BW_BLOCK;

	// core address views
	// ----------------------------------------
	typedef struct packed {
		logic [BW_TAG-1:0]		tag;				// upper bits, compared in tag memory
		logic [BW_GRP-1:0]		grp;				// selects the group
		logic [BW_BLOCK-1:0]	word;				// word within block
	} cache_addr_fields_t;

	// same 16 bits, seen either flat or split
	typedef union packed {
		logic [BW_WORD_ADDR-1:0]	raw;			// as driven by the core
		cache_addr_fields_t			f;				// as used by the cache
	} cache_addr_u;

endpackage

// File: cache_controller.sv
`timescale 1ns/1ps

module cache_controller
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
(
	input	logic								clock_i,
	input	logic								reset_i,

	// core
	input	logic								core_req_i,		// held until done
	input	logic								core_rw_i,		// 1: write
	input	cache_addr_u						core_addr_i,
	input	logic [31:0]						core_data_i,
	output	logic								core_done_o,	// single pulse
	output	logic								core_hit_o,

	// tag memory
	output	logic								tag_lookup_o,
	output	logic								tag_upd_o,
	output	logic								tag_upd_way_o,
	output	logic								tag_upd_valid_o,
	output	logic								tag_upd_dirty_o,
	output	logic								tag_touch_o,
	output	logic								tag_touch_way_o,
	input	logic								tag_hit_i,
	input	logic								tag_hit_way_i,
	input	logic								tag_victim_way_i,
	input	logic [BW_TAG-1:0]					tag_victim_tag_i,
	input	logic								tag_victim_dirty_i,

	// data memory
	output	logic [BW_CACHE_ADDR_FULL-1:0]		mem_addr_o,
	output	logic								mem_wren_o,
	output	logic [31:0]						mem_wdata_o,
	input	logic [31:0]						mem_rdata_i,

	// buffer and memory
	input	logic								ready_req_i,
	output	mem_cmd_t							mem_cmd_o,
	input	logic								ready_write_i,
	output	logic								write_o,
	output	logic [31:0]						data_o,
	input	logic								ready_read_i,
	output	logic								read_o,
	input	logic [31:0]						data_i,

	output	perf_flags_t						flags_o
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_HIT,
		S_WB_CMD,
		S_WB_BURST,
		S_FILL_CMD,
		S_FILL_BURST,
		S_REPLAY
	} state_t;

	state_t					state_q, state_d;
	logic [BW_BLOCK-1:0]	cnt_q;					// burst word, wraps after 4
	logic					first_q;				// no miss seen for this request
	logic					way_sel;
	logic [BW_BLOCK-1:0]	word_sel;

	// state and burst count
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= S_IDLE;
			cnt_q <= '0;
			first_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == S_IDLE) begin
				cnt_q <= '0;
				first_q <= 1'b1;					// fresh request
			end else if (write_o || read_o) begin
				cnt_q <= cnt_q + 1'b1;
			end
			if (state_q == S_LOOKUP && !tag_hit_i) first_q <= 1'b0;
		end
	end

	// next state and strobes
	// ----------------------------------------
	always_comb begin
		state_d = state_q;
		tag_lookup_o = 1'b0;
		tag_upd_o = 1'b0;
		tag_upd_way_o = tag_victim_way_i;
		tag_upd_valid_o = 1'b1;
		tag_upd_dirty_o = 1'b0;
		tag_touch_o = 1'b0;
		tag_touch_way_o = tag_hit_way_i;
		mem_wren_o = 1'b0;
		mem_wdata_o = core_data_i;
		mem_cmd_o = '0;
		write_o = 1'b0;
		read_o = 1'b0;
		flags_o = '0;
		way_sel = tag_victim_way_i;					// bursts work on the victim
		word_sel = cnt_q;

		case (state_q)
			S_IDLE: begin
				tag_lookup_o = core_req_i;
				if (core_req_i) state_d = S_LOOKUP;
			end
			S_LOOKUP: begin
				if (tag_hit_i) begin
					way_sel = tag_hit_way_i;
					word_sel = core_addr_i.f.word;
					mem_wren_o = core_rw_i;			// ram write at end of this cycle
					tag_touch_o = 1'b1;
					tag_upd_o = core_rw_i;			// writes mark the block dirty
					tag_upd_way_o = tag_hit_way_i;
					tag_upd_dirty_o = 1'b1;
					flags_o.hit = first_q;			// replays do not count
					state_d = S_HIT;
				end else begin
					flags_o.miss = 1'b1;
					state_d = tag_victim_dirty_i ? S_WB_CMD : S_FILL_CMD;
				end
			end
			S_HIT: state_d = S_IDLE;				// done pulse
			S_WB_CMD: begin
				mem_cmd_o.req = 1'b1;
				mem_cmd_o.rw = 1'b1;
				mem_cmd_o.add = {tag_victim_tag_i, core_addr_i.f.grp, {BW_BLOCK{1'b0}}};
				if (ready_req_i) begin
					flags_o.writeback = 1'b1;
					state_d = S_WB_BURST;
				end
			end
			S_WB_BURST: begin
				write_o = ready_write_i;
				word_sel = cnt_q + BW_BLOCK'(write_o);	// prefetch next word on a pulse
				if (write_o && (&cnt_q)) state_d = S_FILL_CMD;
			end
			S_FILL_CMD: begin
				mem_cmd_o.req = 1'b1;
				mem_cmd_o.add = {core_addr_i.f.tag, core_addr_i.f.grp, {BW_BLOCK{1'b0}}};
				if (ready_req_i) state_d = S_FILL_BURST;
			end
			S_FILL_BURST: begin
				read_o = ready_read_i;
				mem_wren_o = read_o;
				mem_wdata_o = data_i;
				if (read_o && (&cnt_q)) begin
					tag_upd_o = 1'b1;				// new tag, clean and valid
					state_d = S_REPLAY;
				end
			end
			S_REPLAY: begin
				tag_lookup_o = 1'b1;				// now a guaranteed hit
				state_d = S_LOOKUP;
			end
			default: state_d = S_IDLE;
		endcase
	end

	assign mem_addr_o = {way_sel, core_addr_i.f.grp, word_sel};
	assign data_o = mem_rdata_i;					// ram word leads write_o by a cycle
	assign core_done_o = (state_q == S_HIT);
	assign core_hit_o = (state_q == S_HIT) && first_q;

	// protocol checks
	// ----------------------------------------
	// command fields held while the buffer is not ready
	assert property (@(posedge clock_i) disable iff (reset_i)
		mem_cmd_o.req && !ready_req_i |=> mem_cmd_o.req && $stable(mem_cmd_o));
	// burst word held through a write gap
	assert property (@(posedge clock_i) disable iff (reset_i)
		state_q == S_WB_BURST && !write_o |=> $stable(data_o));
	// the replay after a fill always hits
	assert property (@(posedge clock_i) disable iff (reset_i)
		state_q == S_LOOKUP && !first_q |-> tag_hit_i);

endmodule

// File: cache_data_memory.sv
`timescale 1ns/1ps

module cache_data_memory
	import cache_cfg_pkg::*;
(
	input	logic								clock_i,
	input	logic [BW_CACHE_ADDR_FULL-1:0]		addr_i,		// [way|group|word]
	input	logic								wren_i,
	input	logic [31:0]						data_i,
	output	logic [31:0]						data_o		// one cycle after addr_i
);

	// storage for all ways
	// ----------------------------------------
	logic [31:0]	ram_q [1<<BW_CACHE_ADDR_FULL];

	// single port, read returns the old word on a write
	always_ff @(posedge clock_i) begin
		if (wren_i) ram_q[addr_i] <= data_i;
		data_o <= ram_q[addr_i];
	end

endmodule

// File: cache_perf_counters.sv
`timescale 1ns/1ps

module cache_perf_counters
	import cache_bus_pkg::*;
(
	input	logic			clock_i,
	input	logic			reset_i,
	input	perf_flags_t	flags_i,				// pulses from the controller
	input	logic [31:0]	comm_i,					// [1:0] select, [31] clear
	output	logic [31:0]	comm_o
);

	logic [31:0]	hit_cnt_q;
	logic [31:0]	miss_cnt_q;
	logic [31:0]	wb_cnt_q;

	// counters
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i || comm_i[COMM_CLEAR_BIT]) begin
			hit_cnt_q <= '0;
			miss_cnt_q <= '0;
			wb_cnt_q <= '0;
		end else begin
			if (flags_i.hit) hit_cnt_q <= hit_cnt_q + 32'd1;
			if (flags_i.miss) miss_cnt_q <= miss_cnt_q + 32'd1;
			if (flags_i.writeback) wb_cnt_q <= wb_cnt_q + 32'd1;
		end
	end

	// registered readback
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			comm_o <= '0;
		end else begin
			case (comm_i[1:0])
				COMM_SEL_HIT:	comm_o <= hit_cnt_q;
				COMM_SEL_MISS:	comm_o <= miss_cnt_q;
				COMM_SEL_WB:	comm_o <= wb_cnt_q;
				default:		comm_o <= '0;		// unused selector
			endcase
		end
	end

endmodule

// File: cache_tag_memory.sv
`timescale 1ns/1ps

module cache_tag_memory
	import cache_cfg_pkg::*;
(
	input	logic					clock_i,
	input	logic					reset_i,
	input	logic					lookup_i,		// compare both ways, result next cycle
	input	cache_addr_u			addr_i,			// tag and group of the request
	input	logic					upd_i,			// write tag and flags
	input	logic					upd_way_i,
	input	logic					upd_valid_i,
	input	logic					upd_dirty_i,
	input	logic					touch_i,		// mark an access for lru
	input	logic					touch_way_i,
	output	logic					hit_o,
	output	logic					hit_way_o,
	output	logic					victim_way_o,
	output	logic [BW_TAG-1:0]		victim_tag_o,
	output	logic					victim_dirty_o
);

	// state per group
	// ----------------------------------------
	logic [BW_TAG-1:0]						tag_q [N_WAYS][1<<BW_GRP];	// no reset, guarded by valid
	logic [(1<<BW_GRP)-1:0][N_WAYS-1:0]		valid_q;
	logic [(1<<BW_GRP)-1:0][N_WAYS-1:0]		dirty_q;
	logic [(1<<BW_GRP)-1:0]					lru_q;		// index of least recent way

	logic [BW_GRP-1:0]		grp;
	logic [N_WAYS-1:0]		way_match;
	logic					victim_way;

	assign grp = addr_i.f.grp;

	// compare and replacement choice
	always_comb begin
		for (int w = 0; w < N_WAYS; w++) begin
			way_match[w] = valid_q[grp][w] && (tag_q[w][grp] == addr_i.f.tag);
		end
		if (!valid_q[grp][0]) begin
			victim_way = 1'b0;						// empty way first
		end else if (!valid_q[grp][1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[grp];				// both full, evict lru
		end
	end

	always_ff @(posedge clock_i) begin
		if (upd_i) tag_q[upd_way_i][grp] <= addr_i.f.tag;
		if (lookup_i) begin
			hit_way_o <= way_match[1];				// only meaningful with hit_o
			victim_way_o <= victim_way;
			victim_tag_o <= tag_q[victim_way][grp];
			victim_dirty_o <= valid_q[grp][victim_way] & dirty_q[grp][victim_way];
		end
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
			hit_o <= 1'b0;
		end else begin
			if (upd_i) begin
				valid_q[grp][upd_way_i] <= upd_valid_i;
				dirty_q[grp][upd_way_i] <= upd_dirty_i;
			end
			if (touch_i) lru_q[grp] <= ~touch_way_i;	// other way becomes lru
			if (lookup_i) hit_o <= |way_match;
		end
	end

	// a block is never cached twice in one group
	assert property (@(posedge clock_i) disable iff (reset_i)
		!(&valid_q[grp] && (tag_q[0][grp] == tag_q[1][grp])));

endmodule

// File: project.f
cache_cfg_pkg.sv
cache_bus_pkg.sv
cache_tag_memory.sv
cache_data_memory.sv
cache_controller.sv
cache_perf_counters.sv
cache_2way.sv
tb_ext_memory.sv
tb_cache_2way.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_2way -f project.f || exit 1
sim_out=$(./obj_dir/Vtb_cache_2way)
echo "$sim_out"
echo "$sim_out" | grep -qx "SIMULATION PASSED" && echo "run passed" || { echo "run failed"; exit 1; }

// File: tb_cache_2way.sv
`timescale 1ns/1ps

module tb_cache_2way
	import cache_cfg_pkg::*;
	import cache_bus_pkg::*;
();

	localparam int			N_REQ = 400;
	localparam int			WORST_CYCLES = 40;				// per request, gaps included
	localparam int			WATCHDOG_NS = (8 + N_REQ * WORST_CYCLES + 50) * 20;
	localparam logic [31:0]	SEED = 32'h50d9814f;
	localparam logic [15:0]	WINDOW_BASE = 16'ha400;			// 1K words, 8 tags per group

	logic			clock_i, reset_i;
	logic [31:0]	comm_i, comm_o;
	logic			core_req_i, core_rw_i, core_done_o, hit_o;
	logic [15:0]	core_add_i;
	logic [31:0]	core_data_i, core_data_o;
	logic			ready_req_i, ready_write_i, ready_read_i;
	logic			req_o, rw_o, write_o, read_o;
	logic [15:0]	add_o;
	logic [31:0]	data_i, data_o;

	// reference model
	// ----------------------------------------
	logic [31:0]		ref_mem [1<<BW_WORD_ADDR];			// what the core must see
	logic [BW_TAG-1:0]	m_tag [N_WAYS][1<<BW_GRP];
	logic				m_valid [N_WAYS][1<<BW_GRP];
	logic				m_dirty [N_WAYS][1<<BW_GRP];
	logic				m_lru [1<<BW_GRP];					// least recent way
	logic [31:0]		rand_state;
	int					errors, n_hit, n_miss, n_wb;
	logic				exp_wb;
	logic [15:0]		exp_wb_base, exp_fill_base;
	int					wb_cmds, rd_cmds, wb_words, rd_words;	// per request

	cache_2way DUT (.*);

	tb_ext_memory #(.SEED(SEED)) ext_mem (
		.clock_i(clock_i), .reset_i(reset_i), .req_i(req_o), .rw_i(rw_o), .add_i(add_o),
		.write_i(write_o), .read_i(read_o), .data_i(data_o), .ready_req_o(ready_req_i),
		.ready_write_o(ready_write_i), .ready_read_o(ready_read_i), .data_o(data_i)
	);

	always #10 clock_i = ~clock_i;

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic logic [31:0] fill_word(input logic [15:0] addr);
		return {addr ^ 16'h5a3c, ~addr};
	endfunction

	// hit check, invalid-first then lru victim, install clean
	task automatic predict(input logic [15:0] addr, input logic rw, output logic exp_hit);
		logic [BW_TAG-1:0]	tag;
		logic [BW_GRP-1:0]	grp;
		logic				way;
		tag = addr[BW_WORD_ADDR-1 -: BW_TAG];
		grp = addr[BW_BLOCK +: BW_GRP];
		exp_hit = 1'b0;
		exp_wb = 1'b0;
		way = 1'b0;
		for (int w = 0; w < N_WAYS; w++) begin
			if (m_valid[w][grp] && m_tag[w][grp] == tag) begin
				exp_hit = 1'b1;
				way = (w == 1);
			end
		end
		if (!exp_hit) begin
			way = !m_valid[0][grp] ? 1'b0 : (!m_valid[1][grp] ? 1'b1 : m_lru[grp]);
			exp_wb = m_valid[way][grp] && m_dirty[way][grp];
			exp_wb_base = {m_tag[way][grp], grp, 2'b00};
			m_tag[way][grp] = tag;
			m_valid[way][grp] = 1'b1;
			m_dirty[way][grp] = 1'b0;
		end
		m_lru[grp] = ~way;
		if (rw) m_dirty[way][grp] = 1'b1;
		if (exp_hit) n_hit++;
		else n_miss++;
		if (exp_wb) n_wb++;
	endtask

	// memory side monitor
	// ----------------------------------------
	always @(negedge clock_i) begin
		if (!reset_i) begin
			if (req_o && ready_req_i && rw_o) begin
				wb_cmds++;
				if (!exp_wb) begin
					errors++;
					$display("writeback of block %h that the model holds clean or absent", add_o);
				end else if (add_o !== exp_wb_base) begin
					errors++;
					$display("error: add_o = %h, expected %h", add_o, exp_wb_base);
				end
			end else if (req_o && ready_req_i) begin
				rd_cmds++;
				if (add_o !== exp_fill_base) begin
					errors++;
					$display("error: add_o = %h, expected %h", add_o, exp_fill_base);
				end
			end
			if (write_o) begin
				if (data_o !== ref_mem[exp_wb_base + 16'(wb_words)]) begin
					errors++;
					$display("error: data_o = %h, expected %h", data_o,
						ref_mem[exp_wb_base + 16'(wb_words)]);
				end
				wb_words++;
			end
			if (read_o) rd_words++;
		end
	end

	task automatic run_request();
		logic [31:0]	r, wdata;
		logic [15:0]	addr;
		logic			rw, exp_hit, done;
		int				cycles;
		r = next_rand();
		wdata = next_rand();
		addr = WINDOW_BASE | {6'd0, r[9:0]};
		rw = r[16];
		predict(addr, rw, exp_hit);
		exp_fill_base = {addr[15:2], 2'b00};
		wb_cmds = 0;
		rd_cmds = 0;
		wb_words = 0;
		rd_words = 0;
		@(posedge clock_i);
		#1;
		core_req_i = 1'b1;
		core_rw_i = rw;
		core_add_i = addr;
		core_data_i = wdata;
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge clock_i);
			#1;
			cycles++;
			done = core_done_o;
		end
		if (hit_o !== exp_hit) begin
			errors++;
			$display("error: hit_o = %h, expected %h at %h", hit_o, exp_hit, addr);
		end
		if (exp_hit && cycles != 2) begin
			errors++;
			$display("hit at %h took %0d cycles instead of 2", addr, cycles);
		end
		if (!rw && core_data_o !== ref_mem[addr]) begin
			errors++;
			$display("error: core_data_o = %h, expected %h at %h", core_data_o, ref_mem[addr], addr);
		end
		if (wb_cmds != (exp_wb ? 1 : 0) || wb_words != (exp_wb ? 4 : 0)) begin
			errors++;
			$display("writeback at %h moved %0d commands and %0d words", addr, wb_cmds, wb_words);
		end
		if (rd_cmds != (exp_hit ? 0 : 1) || rd_words != (exp_hit ? 0 : 4)) begin
			errors++;
			$display("fill at %h moved %0d commands and %0d words", addr, rd_cmds, rd_words);
		end
		core_req_i = 1'b0;
		if (rw) ref_mem[addr] = wdata;
	endtask

	task automatic read_counter(input logic [1:0] sel, input int expected, input string name);
		@(posedge clock_i);
		#1;
		comm_i = {30'd0, sel};
		@(posedge clock_i);
		#1;
		if (comm_o !== 32'(expected)) begin
			errors++;
			$display("error: comm_o (%s) = %h, expected %h", name, comm_o, 32'(expected));
		end
	endtask

	// main sequence
	// ----------------------------------------
	initial begin
		logic [16:0]	a;
		clock_i = 1'b0;
		reset_i = 1'b1;
		comm_i = '0;
		core_req_i = 1'b0;
		core_rw_i = 1'b0;
		core_add_i = '0;
		core_data_i = '0;
		rand_state = SEED;
		errors = 0;
		n_hit = 0;
		n_miss = 0;
		n_wb = 0;
		exp_wb = 1'b0;
		exp_wb_base = '0;
		exp_fill_base = '0;
		for (a = '0; a < 17'h10000; a++) ref_mem[a[15:0]] = fill_word(a[15:0]);
		for (int g = 0; g < (1 << BW_GRP); g++) begin
			m_valid[0][g] = 1'b0;
			m_valid[1][g] = 1'b0;
			m_dirty[0][g] = 1'b0;
			m_dirty[1][g] = 1'b0;
			m_lru[g] = 1'b0;
		end
		repeat (8) @(posedge clock_i);
		#1;
		reset_i = 1'b0;
		for (int i = 0; i < N_REQ; i++) run_request();
		read_counter(COMM_SEL_HIT, n_hit, "hit");
		read_counter(COMM_SEL_MISS, n_miss, "miss");
		read_counter(COMM_SEL_WB, n_wb, "writeback");
		@(posedge clock_i);
		#1;
		comm_i = 32'h8000_0000;						// clear, takes one edge
		read_counter(COMM_SEL_HIT, 0, "hit");
		read_counter(COMM_SEL_MISS, 0, "miss");
		read_counter(COMM_SEL_WB, 0, "writeback");
		$display("%0d errors in %0d requests (%0d hits, %0d misses, %0d writebacks)",
			errors, N_REQ, n_hit, n_miss, n_wb);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the cache stopped completing requests");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: tb_ext_memory.sv
`timescale 1ns/1ps

module tb_ext_memory #(
	parameter logic [31:0]	SEED = 32'h1
) (
	input	logic			clock_i,
	input	logic			reset_i,
	input	logic			req_i,			// command from the cache
	input	logic			rw_i,
	input	logic [15:0]	add_i,
	input	logic			write_i,		// cache pushes a word
	input	logic			read_i,			// cache takes a word
	input	logic [31:0]	data_i,
	output	logic			ready_req_o,
	output	logic			ready_write_o,
	output	logic			ready_read_o,
	output	logic [31:0]	data_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ} burst_t;

	logic [31:0]	mem_q [1<<16];
	logic [31:0]	rand_state;
	burst_t			state;
	logic [15:0]	base;					// block base of the open burst
	logic [1:0]		cnt;					// word within burst

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic logic [31:0] fill_word(input logic [15:0] addr);
		return {addr ^ 16'h5a3c, ~addr};	// every address bit shows up
	endfunction

	// drive after the edge, sample mid-cycle
	// ----------------------------------------
	initial begin
		logic [16:0]	a;
		logic [31:0]	r;
		ready_req_o = 1'b0;
		ready_write_o = 1'b0;
		ready_read_o = 1'b0;
		data_o = '0;
		rand_state = SEED;
		state = ST_IDLE;
		base = '0;
		cnt = '0;
		for (a = '0; a < 17'h10000; a++) mem_q[a[15:0]] = fill_word(a[15:0]);
		forever begin
			@(posedge clock_i);
			#1;
			r = next_rand();
			ready_req_o = !reset_i && (r[31:30] != 2'b00);		// roughly one gap in four
			ready_write_o = (state == ST_WRITE) && (r[29:28] != 2'b00);
			ready_read_o = (state == ST_READ) && (r[27:26] != 2'b00);
			data_o = mem_q[base + 16'(cnt)];					// next word of a fill
			@(negedge clock_i);
			if (reset_i) begin
				state = ST_IDLE;
			end else if (req_i && ready_req_o) begin
				base = add_i;
				cnt = '0;
				state = rw_i ? ST_WRITE : ST_READ;
			end else if ((state == ST_WRITE && write_i) || (state == ST_READ && read_i)) begin
				if (state == ST_WRITE) mem_q[base + 16'(cnt)] = data_i;
				if (cnt == 2'd3) state = ST_IDLE;				// block complete
				cnt = cnt + 2'd1;
			end
		end
	end

endmodule
